/* include/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// ALU opcodes used outside data processing
`define CTRL_OP_ADD    4'b0100  // Loads and stores with U set, branches
`define CTRL_OP_SUB    4'b0010  // Loads and stores with U clear
`define CTRL_OP_MOV    4'b1101  // BX passes Rm through to the PC

// Condition field codes, bits 31:28
`define CTRL_COND_EQ   4'b0000
`define CTRL_COND_NE   4'b0001
`define CTRL_COND_CS   4'b0010
`define CTRL_COND_CC   4'b0011
`define CTRL_COND_MI   4'b0100
`define CTRL_COND_PL   4'b0101
`define CTRL_COND_VS   4'b0110
`define CTRL_COND_VC   4'b0111
`define CTRL_COND_HI   4'b1000
`define CTRL_COND_LS   4'b1001
`define CTRL_COND_GE   4'b1010
`define CTRL_COND_LT   4'b1011
`define CTRL_COND_GT   4'b1100
`define CTRL_COND_LE   4'b1101
`define CTRL_COND_AL   4'b1110

`define CTRL_PSR_W     12       // Flags, undef bit, mode field

`define CTRL_VEC_UNDEF 7'h04    // Undefined instruction vector
`define CTRL_VEC_NONE  7'h00

`endif

/* verilog/ctrlPkg.sv */
package ctrlPkg;

  // ========================================
  // Condition flags
  // ========================================
  typedef struct packed {
    logic n;  // Negative
    logic z;  // Zero
    logic c;  // Carry
    logic v;  // Overflow
  } flagsT;

  // ========================================
  // Decode stage bundle
  // ========================================
  typedef struct packed {
    logic [1:0] regSrc;    // Register file read port selects
    logic [1:0] immSrc;    // Immediate extension format
    logic       aluSrc;    // ALU B from immediate
    logic       memtoReg;  // Result from memory
    logic       regWrite;
    logic       memWrite;
    logic       branch;    // B or BX
    logic       aluOp;     // Data processing, opcode from bits 24:21
    logic       bx;
    logic       halfword;  // Halfword family encoding
  } decodeCtrlT;

  // ========================================
  // Payloads of the stage registers
  // ========================================
  typedef struct packed {
    logic       aluSrc;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic [3:0] aluControl;
    logic [1:0] flagWrite;   // Bit 1 for N and Z, bit 0 for C and V
    logic       pcSrc;
    logic [3:0] cond;
    logic       byteAccess;  // LDRB, STRB, LDRSB
    logic       loadHalf;    // 16-bit access length
    logic       undef;
  } exCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;    // Byte-lane write enables
    logic [1:0] byteOffset;  // Address low bits for load extraction
    logic       loadByte;
    logic       writeHalf;
    logic       undef;
  } memCtrlT;

  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
    logic       writeHalf;
    logic       undef;
  } wbCtrlT;

  // Flags in flight from E to W
  typedef struct packed {
    flagsT flags;
    logic  set;  // Flags were written by a passing instruction
  } flagUpdT;

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/100ps
`include "ctrl_defs.svh"

module instrDecoder (
  input  logic [31:0]         instrD,
  output ctrlPkg::decodeCtrlT ctrlD,
  output logic [3:0]          aluControlD,
  output logic [1:0]          flagWriteD,
  output logic                pcSrcD,
  output logic                byteAccessD,
  output logic                loadHalfD,
  output logic                undefD
);

  logic isHalfFam;  // LDRH, STRH, LDRSB, LDRSH
  logic isMul;      // MUL and MLA
  logic isLongMul;  // UMULL and friends, not supported
  logic isBx;
  logic memAccess;

  assign isHalfFam = (instrD[27:25] == 3'b000) & instrD[7] & instrD[4] &
                     (instrD[6:5] != 2'b00);
  assign isMul     = (instrD[27:22] == 6'b000000) & (instrD[7:4] == 4'b1001);
  assign isLongMul = (instrD[27:23] == 5'b00001) & (instrD[7:4] == 4'b1001);
  assign isBx      = (instrD[27:4] == 24'h12_FFF1);

  // ========================================
  // Main control bundle
  // ========================================
  always_comb begin
    ctrlD  = '0;  // Unused encodings write nothing
    undefD = 1'b0;
    case (instrD[27:26])
      2'b00: begin
        if (instrD[25]) begin  // Data processing immediate
          ctrlD.aluSrc   = 1'b1;
          ctrlD.regWrite = 1'b1;
          ctrlD.aluOp    = 1'b1;
        end else if (isMul) begin
          ctrlD.regWrite = 1'b1;  // Result from multiplier
        end else if (isLongMul) begin
          undefD = 1'b1;
        end else if (isHalfFam) begin
          ctrlD.immSrc   = 2'b11;       // Split 8-bit offset
          ctrlD.aluSrc   = instrD[22];  // Immediate offset form
          ctrlD.halfword = 1'b1;
          if (instrD[20]) begin
            ctrlD.memtoReg = 1'b1;
            ctrlD.regWrite = 1'b1;
          end else begin
            ctrlD.regSrc   = 2'b10;  // Read Rd as store data
            ctrlD.memWrite = 1'b1;
          end
        end else if (isBx) begin
          ctrlD.regSrc = 2'b01;
          ctrlD.branch = 1'b1;
          ctrlD.bx     = 1'b1;
        end else begin  // Data processing register
          ctrlD.regWrite = 1'b1;
          ctrlD.aluOp    = 1'b1;
        end
      end
      2'b01: begin
        if (instrD[25] & instrD[4]) begin
          undefD = 1'b1;  // Register-shifted offset is undefined here
        end else begin
          ctrlD.immSrc = 2'b01;        // 12-bit offset
          ctrlD.aluSrc = ~instrD[25];  // I bit clear means immediate
          if (instrD[20]) begin
            ctrlD.memtoReg = 1'b1;
            ctrlD.regWrite = 1'b1;
          end else begin
            ctrlD.regSrc   = 2'b10;
            ctrlD.memWrite = 1'b1;
          end
        end
      end
      2'b10: begin  // B
        ctrlD.regSrc = 2'b01;  // PC as Rn
        ctrlD.immSrc = 2'b10;  // 24-bit word offset
        ctrlD.aluSrc = 1'b1;
        ctrlD.branch = 1'b1;
      end
      default: undefD = 1'b1;  // Coprocessor and SWI space
    endcase
  end

  // ========================================
  // ALU control and flag writes
  // ========================================
  assign memAccess = (instrD[27:26] == 2'b01) | ctrlD.halfword;

  always_comb begin
    aluControlD = `CTRL_OP_ADD;  // Branch target add by default
    flagWriteD  = 2'b00;
    if (ctrlD.aluOp) begin
      aluControlD = instrD[24:21];
      flagWriteD  = {2{instrD[20]}};  // S bit
    end else if (memAccess) begin
      aluControlD = instrD[23] ? `CTRL_OP_ADD : `CTRL_OP_SUB;  // U bit
    end else if (ctrlD.bx) begin
      aluControlD = `CTRL_OP_MOV;
    end else if (isMul) begin
      flagWriteD = {instrD[20], 1'b0};  // MULS sets N and Z only
    end
  end

  // Writes to r15 and branches redirect fetch
  assign pcSrcD = (ctrlD.regWrite & ~isMul & (instrD[15:12] == 4'hF)) | ctrlD.branch;

  assign byteAccessD = ((instrD[27:26] == 2'b01) & instrD[22]) |  // B bit
                       (isHalfFam & ~instrD[5]);                  // LDRSB
  assign loadHalfD   = isHalfFam & instrD[5];                     // H bit

endmodule

/* verilog/condCheck.sv */
`timescale 1ns/100ps
`include "ctrl_defs.svh"

module condCheck (
  input  logic [3:0]     cond,
  input  ctrlPkg::flagsT flagsIn,   // Forwarded flags
  input  ctrlPkg::flagsT aluFlags,
  input  logic [1:0]     flagWrite,
  output logic           condEx,
  output ctrlPkg::flagsT flagsNext
);

  logic updNz;
  logic updCv;

  // ========================================
  // Condition evaluation
  // ========================================
  always_comb begin
    case (cond)
      `CTRL_COND_EQ: condEx = flagsIn.z;
      `CTRL_COND_NE: condEx = ~flagsIn.z;
      `CTRL_COND_CS: condEx = flagsIn.c;
      `CTRL_COND_CC: condEx = ~flagsIn.c;
      `CTRL_COND_MI: condEx = flagsIn.n;
      `CTRL_COND_PL: condEx = ~flagsIn.n;
      `CTRL_COND_VS: condEx = flagsIn.v;
      `CTRL_COND_VC: condEx = ~flagsIn.v;
      `CTRL_COND_HI: condEx = flagsIn.c & ~flagsIn.z;   // Unsigned higher
      `CTRL_COND_LS: condEx = ~flagsIn.c | flagsIn.z;
      `CTRL_COND_GE: condEx = (flagsIn.n == flagsIn.v);  // Signed compares
      `CTRL_COND_LT: condEx = (flagsIn.n != flagsIn.v);
      `CTRL_COND_GT: condEx = ~flagsIn.z & (flagsIn.n == flagsIn.v);
      `CTRL_COND_LE: condEx = flagsIn.z | (flagsIn.n != flagsIn.v);
      `CTRL_COND_AL: condEx = 1'b1;
      default:       condEx = 1'b0;  // 1111 never executes here
    endcase
  end

  // ========================================
  // Flag merge
  // ========================================
  assign updNz = condEx & flagWrite[1];
  assign updCv = condEx & flagWrite[0];

  // Untouched flags keep their forwarded value
  assign flagsNext.n = updNz ? aluFlags.n : flagsIn.n;
  assign flagsNext.z = updNz ? aluFlags.z : flagsIn.z;
  assign flagsNext.c = updCv ? aluFlags.c : flagsIn.c;
  assign flagsNext.v = updCv ? aluFlags.v : flagsIn.v;

endmodule

/* verilog/byteMask.sv */
`timescale 1ns/100ps

module byteMask (
  input  logic       byteAccess,
  input  logic       halfAccess,
  input  logic [1:0] addrLow,  // Low bits of the ALU address
  output logic [3:0] mask
);

  // Little-endian lanes, lane 0 is bits 7:0
  always_comb begin
    if (byteAccess) begin
      case (addrLow)
        2'b00:   mask = 4'b0001;
        2'b01:   mask = 4'b0010;
        2'b10:   mask = 4'b0100;
        default: mask = 4'b1000;
      endcase
    end else if (halfAccess) begin
      mask = addrLow[1] ? 4'b1100 : 4'b0011;  // Bit 0 ignored
    end else begin
      mask = 4'b1111;  // Word
    end
  end

endmodule

/* verilog/statusReg.sv */
`timescale 1ns/100ps
`include "ctrl_defs.svh"

module statusReg (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   en,       // W stage not stalled
  input  ctrlPkg::flagUpdT       flagUpd,
  input  logic                   undef,
  output logic [`CTRL_PSR_W-1:0] psr,
  output logic [6:0]             vector
);

  localparam logic [4:0] ModeSvc = 5'b10011;  // Mode out of reset
  localparam logic [4:0] ModeUnd = 5'b11011;

  ctrlPkg::flagsT flags;
  logic           undefMode;  // Sticky until reset
  logic [4:0]     mode;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags     <= '0;
      undefMode <= 1'b0;
      mode      <= ModeSvc;
      vector    <= `CTRL_VEC_NONE;
    end else begin
      vector <= (en & undef) ? `CTRL_VEC_UNDEF : `CTRL_VEC_NONE;  // One-cycle pulse
      if (en) begin
        if (flagUpd.set) flags <= flagUpd.flags;  // Commit W flags
        if (undef) begin
          undefMode <= 1'b1;
          mode      <= ModeUnd;
        end
      end
    end
  end

  // Flags on top, then undef bit, two reserved bits and mode
  assign psr = {flags, undefMode, 2'b00, mode};

endmodule

/* verilog/armController.sv */
`timescale 1ns/100ps
`include "ctrl_defs.svh"

module armController (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [31:0]            instrD,
  input  ctrlPkg::flagsT         aluFlagsE,
  input  logic [1:0]             aluAddrE,   // ALU result bits 1:0
  input  logic                   stallE,
  input  logic                   flushE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushW,
  output logic [1:0]             regSrcD,
  output logic [1:0]             immSrcD,
  output logic                   aluSrcE,
  output logic                   branchTakenE,
  output logic                   memtoRegE,  // To hazard unit
  output logic [3:0]             aluControlE,
  output ctrlPkg::memCtrlT       memCtrlM,
  output ctrlPkg::wbCtrlT        wbCtrlW,
  output logic [`CTRL_PSR_W-1:0] psrW,
  output logic [6:0]             vectorW,
  output logic                   pcWrPendingF
);

  ctrlPkg::decodeCtrlT ctrlD;
  logic [3:0]          aluControlD;
  logic [1:0]          flagWriteD;
  logic                pcSrcD, byteAccessD, loadHalfD, undefD;
  ctrlPkg::exCtrlT     exCtrlD, exCtrlE;

  ctrlPkg::flagsT      flagsFwdE, flagsNextE;
  logic                condExE;
  logic                flagOnlyE;  // TST, TEQ, CMP, CMN
  logic [3:0]          byteMaskE;
  ctrlPkg::memCtrlT    memCtrlE;
  ctrlPkg::flagUpdT    flagUpdE, flagUpdM, flagUpdW;
  ctrlPkg::wbCtrlT     wbCtrlM;

  // ========================================
  // Decode
  // ========================================
  instrDecoder instrDecoder_inst (
    .instrD      (instrD),
    .ctrlD       (ctrlD),
    .aluControlD (aluControlD),
    .flagWriteD  (flagWriteD),
    .pcSrcD      (pcSrcD),
    .byteAccessD (byteAccessD),
    .loadHalfD   (loadHalfD),
    .undefD      (undefD)
  );

  assign regSrcD = ctrlD.regSrc;
  assign immSrcD = ctrlD.immSrc;

  always_comb begin
    exCtrlD.aluSrc     = ctrlD.aluSrc;
    exCtrlD.memtoReg   = ctrlD.memtoReg;
    exCtrlD.regWrite   = ctrlD.regWrite;
    exCtrlD.memWrite   = ctrlD.memWrite;
    exCtrlD.branch     = ctrlD.branch;
    exCtrlD.aluControl = aluControlD;
    exCtrlD.flagWrite  = flagWriteD;
    exCtrlD.pcSrc      = pcSrcD;
    exCtrlD.cond       = instrD[31:28];
    exCtrlD.byteAccess = byteAccessD;
    exCtrlD.loadHalf   = loadHalfD;
    exCtrlD.undef      = undefD;
  end

  // D/E register, flush wins over stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)        exCtrlE <= '0;
    else if (flushE)  exCtrlE <= '0;      // Bubble
    else if (!stallE) exCtrlE <= exCtrlD;
  end

  // ========================================
  // Execute
  // ========================================
  // Youngest pending update wins, then the committed flags
  assign flagsFwdE = flagUpdM.set ? flagUpdM.flags :
                     flagUpdW.set ? flagUpdW.flags :
                     ctrlPkg::flagsT'(psrW[`CTRL_PSR_W-1 -: 4]);

  condCheck condCheck_inst (
    .cond      (exCtrlE.cond),
    .flagsIn   (flagsFwdE),
    .aluFlags  (aluFlagsE),
    .flagWrite (exCtrlE.flagWrite),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  byteMask byteMask_inst (
    .byteAccess (exCtrlE.byteAccess),
    .halfAccess (exCtrlE.loadHalf),
    .addrLow    (aluAddrE),
    .mask       (byteMaskE)
  );

  assign aluSrcE      = exCtrlE.aluSrc;
  assign aluControlE  = exCtrlE.aluControl;
  assign memtoRegE    = exCtrlE.memtoReg;
  assign branchTakenE = exCtrlE.branch & condExE;

  // Compare and test opcodes only touch flags
  assign flagOnlyE = (exCtrlE.aluControl[3:2] == 2'b10);

  always_comb begin
    memCtrlE.memWrite   = exCtrlE.memWrite & condExE;
    memCtrlE.memtoReg   = exCtrlE.memtoReg;
    memCtrlE.regWrite   = exCtrlE.regWrite & condExE & ~flagOnlyE;
    memCtrlE.pcSrc      = exCtrlE.pcSrc & condExE;
    memCtrlE.byteMask   = byteMaskE;
    memCtrlE.byteOffset = aluAddrE;
    memCtrlE.loadByte   = exCtrlE.byteAccess;
    memCtrlE.writeHalf  = exCtrlE.loadHalf;
    memCtrlE.undef      = exCtrlE.undef & condExE;  // Skipped instructions never trap
  end

  assign flagUpdE.flags = flagsNextE;
  assign flagUpdE.set   = condExE & (|exCtrlE.flagWrite);

  // E/M register, no clear
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memCtrlM <= '0;
      flagUpdM <= '0;
    end else if (!stallM) begin
      memCtrlM <= memCtrlE;
      flagUpdM <= flagUpdE;
    end
  end

  // ========================================
  // Memory
  // ========================================
  always_comb begin
    wbCtrlM.memtoReg   = memCtrlM.memtoReg;
    wbCtrlM.regWrite   = memCtrlM.regWrite;
    wbCtrlM.pcSrc      = memCtrlM.pcSrc;
    wbCtrlM.loadByte   = memCtrlM.loadByte;
    wbCtrlM.byteOffset = memCtrlM.byteOffset;
    wbCtrlM.writeHalf  = memCtrlM.writeHalf;
    wbCtrlM.undef      = memCtrlM.undef;
  end

  // M/W register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbCtrlW  <= '0;
      flagUpdW <= '0;
    end else if (flushW) begin
      wbCtrlW  <= '0;
      flagUpdW <= '0;
    end else if (!stallW) begin
      wbCtrlW  <= wbCtrlM;
      flagUpdW <= flagUpdM;
    end
  end

  // ========================================
  // Writeback
  // ========================================
  statusReg statusReg_inst (
    .clk     (clk),
    .rstN    (rstN),
    .en      (~stallW),
    .flagUpd (flagUpdW),
    .undef   (wbCtrlW.undef),
    .psr     (psrW),
    .vector  (vectorW)
  );

  // Fetch must wait while any PC write is in flight
  assign pcWrPendingF = pcSrcD | exCtrlE.pcSrc | memCtrlM.pcSrc;

endmodule

/* test/armController_asserts.sv */
`timescale 1ns/100ps

module armController_asserts (
  input logic             clk,
  input logic             rstN,
  input logic             flushE,
  input logic             stallM,
  input ctrlPkg::memCtrlT memCtrlM,
  input ctrlPkg::wbCtrlT  wbCtrlW
);

  // First edge after reset still sees the cleared registers
  resetQuiet: assert property (@(posedge clk)
    $rose(rstN) |-> !(memCtrlM.regWrite | memCtrlM.memWrite | memCtrlM.pcSrc |
                      wbCtrlW.regWrite | wbCtrlW.pcSrc | wbCtrlW.undef))
    else $error("Write enable active in the first cycle after reset");

  // Bubble from a flushed E moves into M on the next unstalled edge
  flushBubble: assert property (@(posedge clk) disable iff (!rstN)
    ($past(flushE) && !stallM) |=> (!memCtrlM.regWrite && !memCtrlM.memWrite))
    else $error("Flushed E stage reached M with a write enabled");

  // Lanes must match the access width carried along in M
  maskLegal: assert property (@(posedge clk) disable iff (!rstN)
    memCtrlM.memWrite |->
      (memCtrlM.loadByte  ? $onehot(memCtrlM.byteMask) :
       memCtrlM.writeHalf ? (memCtrlM.byteMask inside {4'b0011, 4'b1100}) :
                            (memCtrlM.byteMask == 4'b1111)))
    else $error("Byte mask does not fit the access width");

endmodule

bind armController armController_asserts asserts_inst (
  .clk      (clk),
  .rstN     (rstN),
  .flushE   (flushE),
  .stallM   (stallM),
  .memCtrlM (memCtrlM),
  .wbCtrlW  (wbCtrlW)
);

/* test/armController_tb.sv */
`timescale 1ns/100ps
`include "ctrl_defs.svh"

module armController_tb;

  localparam int TestCycles = 100;             // Rough length of all tests together
  localparam int MaxCycles  = 4 * TestCycles;  // Generous margin

  // ========================================
  // Instruction encodings
  // ========================================
  localparam logic [31:0] InstrNop      = 32'hF000_0000;  // Condition NV, never executes
  localparam logic [31:0] InstrAddsImm  = 32'hE292_1005;  // ADDS r1, r2, #5
  localparam logic [31:0] InstrCmpImm   = 32'hE351_0000;  // CMP r1, #0
  localparam logic [31:0] InstrSubsReg  = 32'hE050_0000;  // SUBS r0, r0, r0
  localparam logic [31:0] InstrMovEq    = 32'h03A0_1001;  // MOVEQ r1, #1
  localparam logic [31:0] InstrMovNe    = 32'h13A0_2002;  // MOVNE r2, #2
  localparam logic [31:0] InstrLdrUp    = 32'hE592_1004;  // LDR r1, [r2, #4]
  localparam logic [31:0] InstrLdrDown  = 32'hE512_1004;  // LDR r1, [r2, #-4]
  localparam logic [31:0] InstrStrb     = 32'hE5C2_1000;  // STRB r1, [r2]
  localparam logic [31:0] InstrStrh     = 32'hE1C2_10B0;  // STRH r1, [r2]
  localparam logic [31:0] InstrStr      = 32'hE582_1000;  // STR r1, [r2]
  localparam logic [31:0] InstrBAl      = 32'hEA00_0010;
  localparam logic [31:0] InstrMovPc    = 32'hE1A0_F00E;  // MOV pc, lr
  localparam logic [31:0] InstrLdrRegSh = 32'hE792_1013;  // Register-shifted offset
  localparam logic [31:0] InstrAndReg   = 32'hE002_1003;  // AND r1, r2, r3

  logic clk, rstN;
  logic [31:0] instrD;
  ctrlPkg::flagsT aluFlagsE;
  logic [1:0] aluAddrE;
  logic stallE, flushE, stallM, stallW, flushW;
  logic [1:0] regSrcD, immSrcD;
  logic aluSrcE, branchTakenE, memtoRegE, pcWrPendingF;
  logic [3:0] aluControlE;
  ctrlPkg::memCtrlT memCtrlM;
  ctrlPkg::wbCtrlT wbCtrlW;
  logic [`CTRL_PSR_W-1:0] psrW;
  logic [6:0] vectorW;

  int checkCount;
  int errorCount;
  int cycleCount;
  ctrlPkg::flagsT committedFlags;  // Expected flags in the status register

  armController armController_inst (.*);

  always #10 clk = ~clk;  // 20 ns period

  // ========================================
  // Helpers
  // ========================================
  task automatic step();
    @(negedge clk);
  endtask

  task automatic settle();
    #1;  // Combinational paths from instrD
  endtask

  task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic expectBit(input string what, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // One store through E into M, mask from the lane rules
  task automatic storeMask(input logic [31:0] instr, input logic isByte, input logic [1:0] addr);
    logic [3:0] exp;
    exp = isByte ? 4'(4'b0001 << addr) : (addr[1] ? 4'b1100 : 4'b0011);
    instrD = instr;
    settle();
    expectEq("store regSrcD", 32'(regSrcD), 32'h2);  // Rd read as store data
    step();
    instrD   = InstrNop;
    aluAddrE = addr;  // Address known in E
    step();
    aluAddrE = 2'b00;
    expectBit("store memWrite in M", memCtrlM.memWrite, 1'b1);
    expectEq(isByte ? "STRB byteMask" : "STRH byteMask", 32'(memCtrlM.byteMask), 32'(exp));
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic dataProcTest();
    logic [3:0]     op;
    logic [31:0]    regInstr;
    ctrlPkg::flagsT flagsA;
    op = 4'($urandom_range(11, 0));
    if (op >= 4'd8) op = op + 4'd4;  // Skip compare and test opcodes
    regInstr = {4'hE, 3'b000, op, 1'b0, 4'd3, 4'd4, 8'h00, 4'd5};
    flagsA   = ctrlPkg::flagsT'(4'($urandom));
    instrD = InstrAddsImm;
    step();                        // ADDS in E
    aluFlagsE = flagsA;
    instrD    = regInstr;
    expectEq("ADDS aluControlE", 32'(aluControlE), 32'h4);
    step();                        // ADDS in M, register form in E
    aluFlagsE = '0;
    instrD    = InstrNop;
    expectBit("ADDS regWrite in M", memCtrlM.regWrite, 1'b1);
    expectEq("register-form aluControlE", 32'(aluControlE), 32'(op));
    step();
    expectBit("register-form regWrite in M", memCtrlM.regWrite, 1'b1);
    step();                        // t+4 for ADDS
    committedFlags = flagsA;
    expectEq("psrW flags after ADDS", 32'(psrW[11:8]), 32'(committedFlags));
    instrD = InstrCmpImm;
    step();
    aluFlagsE = ctrlPkg::flagsT'(4'b0010);  // Carry only, Z clear
    instrD    = InstrNop;
    step();
    aluFlagsE = '0;
    expectBit("CMP regWrite in M", memCtrlM.regWrite, 1'b0);
    repeat (2) step();
    committedFlags = ctrlPkg::flagsT'(4'b0010);
    expectEq("psrW flags after CMP", 32'(psrW[11:8]), 32'(committedFlags));
  endtask

  // Committed Z is clear here, so EQ can only pass by forwarding
  task automatic condGatingTest();
    instrD = InstrSubsReg;
    step();
    aluFlagsE = ctrlPkg::flagsT'(4'b0100);  // Z set
    instrD    = InstrMovEq;
    step();                                 // MOVEQ sees SUBS in M
    aluFlagsE = '0;
    instrD    = InstrMovNe;
    step();                                 // MOVNE sees SUBS in W
    instrD = InstrNop;
    expectBit("MOVEQ regWrite in M", memCtrlM.regWrite, 1'b1);
    step();
    expectBit("MOVNE regWrite in M", memCtrlM.regWrite, 1'b0);
    committedFlags = ctrlPkg::flagsT'(4'b0100);
  endtask

  task automatic loadStoreTest();
    instrD = InstrLdrUp;
    settle();
    expectEq("LDR regSrcD", 32'(regSrcD), 32'h0);
    expectEq("LDR immSrcD", 32'(immSrcD), 32'h1);  // 12-bit offset
    step();
    instrD = InstrLdrDown;
    expectEq("LDR U set aluControlE", 32'(aluControlE), 32'(`CTRL_OP_ADD));
    expectBit("LDR memtoRegE", memtoRegE, 1'b1);
    step();
    instrD = InstrNop;
    expectEq("LDR U clear aluControlE", 32'(aluControlE), 32'(`CTRL_OP_SUB));
    expectBit("LDR memtoReg in M", memCtrlM.memtoReg, 1'b1);
    for (int a = 0; a < 4; a++) begin
      storeMask(InstrStrb, 1'b1, 2'(a));
      storeMask(InstrStrh, 1'b0, 2'(a));
    end
  endtask

  task automatic branchTest();
    logic [3:0] failCond;
    failCond = committedFlags.z ? `CTRL_COND_NE : `CTRL_COND_EQ;
    instrD = InstrBAl;
    settle();
    expectBit("pcWrPendingF with B in D", pcWrPendingF, 1'b1);
    expectEq("B regSrcD", 32'(regSrcD), 32'h1);  // PC as Rn
    expectEq("B immSrcD", 32'(immSrcD), 32'h2);  // 24-bit offset
    step();
    instrD = InstrNop;
    settle();
    expectBit("B AL branchTakenE", branchTakenE, 1'b1);
    expectBit("pcWrPendingF with B in E", pcWrPendingF, 1'b1);
    step();
    expectBit("pcWrPendingF with B in M", pcWrPendingF, 1'b1);
    step();
    expectBit("pcWrPendingF after B", pcWrPendingF, 1'b0);
    instrD = {failCond, 28'hA00_0010};  // Branch that must not execute
    step();
    instrD = InstrNop;
    expectBit("failing branch branchTakenE", branchTakenE, 1'b0);
    step();
    expectBit("failing branch pcSrc in M", memCtrlM.pcSrc, 1'b0);
    instrD = InstrMovPc;
    step();
    instrD = InstrNop;
    repeat (2) step();                  // MOV pc in W
    expectBit("MOV pc pcSrc in W", wbCtrlW.pcSrc, 1'b1);
    expectBit("MOV pc regWrite in W", wbCtrlW.regWrite, 1'b1);
  endtask

  task automatic undefTest();
    instrD = InstrLdrRegSh;
    step();
    instrD = InstrNop;
    repeat (2) step();
    expectEq("vectorW at t+3", 32'(vectorW), 32'(`CTRL_VEC_NONE));
    expectBit("wbCtrlW undef at t+3", wbCtrlW.undef, 1'b1);
    expectBit("psrW undef bit at t+3", psrW[7], 1'b0);
    step();
    expectEq("vectorW at t+4", 32'(vectorW), 32'(`CTRL_VEC_UNDEF));
    expectBit("psrW undef bit at t+4", psrW[7], 1'b1);  // Undefined mode recorded
    step();
    expectEq("vectorW at t+5", 32'(vectorW), 32'(`CTRL_VEC_NONE));  // One-cycle pulse
  endtask

  task automatic stallFlushTest();
    instrD = InstrLdrDown;
    step();                  // LDR in E
    stallE = 1'b1;
    instrD = InstrAndReg;
    repeat (2) begin
      step();
      expectEq("aluControlE under stallE", 32'(aluControlE), 32'(`CTRL_OP_SUB));
      expectBit("aluSrcE under stallE", aluSrcE, 1'b1);
    end
    stallE = 1'b0;
    step();                  // AND enters E
    instrD = InstrNop;
    expectEq("aluControlE after stall", 32'(aluControlE), 32'h0);
    expectBit("aluSrcE after stall", aluSrcE, 1'b0);
    instrD = InstrStr;
    flushE = 1'b1;           // STR replaced by a bubble
    step();
    flushE = 1'b0;
    instrD = InstrNop;
    step();
    expectBit("memWrite in M after flushE", memCtrlM.memWrite, 1'b0);
    expectBit("regWrite in M after flushE", memCtrlM.regWrite, 1'b0);
  endtask

  // ========================================
  // Main sequence and timeout
  // ========================================
  initial begin
    void'($urandom(32'hfb70));
    clk = 1'b0;
    rstN = 1'b0;
    instrD = InstrNop;
    aluFlagsE = '0;
    aluAddrE = 2'b00;
    {stallE, flushE, stallM, stallW, flushW} = '0;
    checkCount = 0;
    errorCount = 0;
    committedFlags = '0;
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    dataProcTest();
    condGatingTest();
    loadStoreTest();
    branchTest();
    undefTest();
    stallFlushTest();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) $display("Test passed");
    else $display("Test failed");
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < MaxCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
    $display("Test failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/condCheck.sv
verilog/byteMask.sv
verilog/statusReg.sv
verilog/armController.sv
test/armController_asserts.sv
test/armController_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module armController_tb -f sources.f -o simv \
  && ./obj_dir/simv 2>&1 | tee sim.log \
  || { echo "Build or simulation aborted"; exit 1; }

grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"
